// ==== build.f ====
+incdir+verif
verilog/bp_cfg_pkg.sv
verilog/bp_types_pkg.sv
verilog/bht_table.sv
verilog/bht_update.sv
verilog/sweep_counter.sv
verilog/flush_fsm.sv
verilog/bp_unit.sv
verif/bp_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module bp_unit_tb -f build.f &&
./obj_dir/Vbp_unit_tb | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }

// ==== verif/bht_model.svh ====
// reference model of the history table with its update pipeline and flush sequencing
`ifndef BHT_MODEL_SVH
`define BHT_MODEL_SVH

logic         m_valid [NR_ROWS][INSTR_PER_FETCH];
sat_cnt_t     m_cnt   [NR_ROWS][INSTR_PER_FETCH];
logic         m_pend;
vaddr_t       m_pend_pc;
logic         m_pend_taken;
flush_state_e m_fl_state;
int           m_fl_cnt;

// slot is bit OFFSET, the row bits sit directly above it
function automatic int row_of(input vaddr_t pc);
  return int'(pc[OFFSET+SLOT_W +: ROW_W]);
endfunction

function automatic int slot_of(input vaddr_t pc);
  return int'(pc[OFFSET +: SLOT_W]);
endfunction

// one saturating step toward the outcome
function automatic sat_cnt_t step_cnt(input sat_cnt_t cnt, input logic taken);
  sat_cnt_t nxt;
  nxt = cnt;
  if (taken && cnt != 2'b11) begin
    nxt = cnt + 2'b01;
  end else if (!taken && cnt != 2'b00) begin
    nxt = cnt - 2'b01;
  end
  return nxt;
endfunction

task automatic fill_table(input logic vld, input sat_cnt_t cnt);
  for (int r = 0; r < NR_ROWS; r++) begin
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      m_valid[r][s] = vld;
      m_cnt[r][s]   = cnt;
    end
  end
endtask

task automatic reset_table_model();
  fill_table(1'b0, 2'b00);
  m_pend       = 1'b0;
  m_pend_pc    = '0;
  m_pend_taken = 1'b0;
  m_fl_state   = FLUSH_IDLE;
  m_fl_cnt     = 0;
endtask

// ------------------------------------------------------------
// one rising edge, with the inputs sampled there
// ------------------------------------------------------------
task automatic follow_edge(input logic vld, input vaddr_t pc, input logic taken,
                           input logic dbg, input logic req);
  logic busy;
  int   r;
  int   s;
  // blocked from the edge that sees the request until the sweep ends
  busy = (m_fl_state == FLUSH_IDLE && req) || m_fl_state == FLUSH_SWEEP;
  // write of the update accepted one edge earlier
  if (m_pend && !busy) begin
    r = row_of(m_pend_pc);
    s = slot_of(m_pend_pc);
    m_cnt[r][s]   = step_cnt(m_cnt[r][s], m_pend_taken);
    m_valid[r][s] = 1'b1;
  end
  m_pend       = vld && !dbg && !busy;
  m_pend_pc    = pc;
  m_pend_taken = taken;
  case (m_fl_state)
    FLUSH_IDLE: begin
      if (req) begin
        m_fl_state = FLUSH_SWEEP;
        m_fl_cnt   = 0;
      end
    end
    FLUSH_SWEEP: begin
      // one row per edge, all rows are clear after the last one
      m_fl_cnt++;
      if (m_fl_cnt == NR_ROWS) begin
        fill_table(1'b0, 2'b10);
        m_fl_state = FLUSH_ACK;
      end
    end
    default: begin
      if (!req) begin
        m_fl_state = FLUSH_IDLE;
      end
    end
  endcase
endtask

function automatic slot_vec_t valid_bits(input vaddr_t pc);
  slot_vec_t v;
  for (int s = 0; s < INSTR_PER_FETCH; s++) begin
    v[s] = m_valid[row_of(pc)][s];
  end
  return v;
endfunction

// taken is the counter's upper bit, valid or not
function automatic slot_vec_t taken_bits(input vaddr_t pc);
  slot_vec_t t;
  for (int s = 0; s < INSTR_PER_FETCH; s++) begin
    t[s] = m_cnt[row_of(pc)][s][1];
  end
  return t;
endfunction

`endif

// ==== verif/bp_unit_tb.sv ====
// testbench for the branch prediction unit: clock, reset, random stimulus, model checks, report
`timescale 1ns/1ps

module bp_unit_tb
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
();

  logic      clk_i;
  logic      rst_ni;
  vaddr_t    fetch_pc_i;
  slot_vec_t pred_valid_o;
  slot_vec_t pred_taken_o;
  logic      upd_valid_i;
  vaddr_t    upd_pc_i;
  logic      upd_taken_i;
  logic      debug_mode_i;
  logic      flush_req_i;
  logic      flush_ack_o;

  // values that go out on the next rising edge
  vaddr_t    nx_fetch_pc;
  logic      nx_upd_valid;
  vaddr_t    nx_upd_pc;
  logic      nx_upd_taken;
  logic      nx_debug;
  logic      nx_req;

  int        errors;
  int        checks;
  string     test_name;

  `include "bht_model.svh"

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  bp_unit u_bp_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_pc_i   (fetch_pc_i),
    .pred_valid_o (pred_valid_o),
    .pred_taken_o (pred_taken_o),
    .upd_valid_i  (upd_valid_i),
    .upd_pc_i     (upd_pc_i),
    .upd_taken_i  (upd_taken_i),
    .debug_mode_i (debug_mode_i),
    .flush_req_i  (flush_req_i),
    .flush_ack_o  (flush_ack_o)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_equal(input string what, input slot_vec_t exp, input slot_vec_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  function automatic vaddr_t make_pc(input int row, input int slot);
    vaddr_t pc;
    pc = $urandom;
    pc[0] = 1'b0;
    pc[OFFSET +: SLOT_W] = slot_idx_t'(slot);
    pc[OFFSET+SLOT_W +: ROW_W] = row_idx_t'(row);
    return pc;
  endfunction

  // model follows the edge, next inputs go out, outputs are compared mid-cycle
  task automatic next_cycle();
    @(posedge clk_i);
    follow_edge(upd_valid_i, upd_pc_i, upd_taken_i, debug_mode_i, flush_req_i);
    fetch_pc_i   <= nx_fetch_pc;
    upd_valid_i  <= nx_upd_valid;
    upd_pc_i     <= nx_upd_pc;
    upd_taken_i  <= nx_upd_taken;
    debug_mode_i <= nx_debug;
    flush_req_i  <= nx_req;
    @(negedge clk_i);
    check_equal("flush_ack_o", slot_vec_t'(m_fl_state == FLUSH_ACK), slot_vec_t'(flush_ack_o));
    // rows are cleared one by one during the sweep
    if (m_fl_state != FLUSH_SWEEP) begin
      check_equal("pred_valid_o", valid_bits(fetch_pc_i), pred_valid_o);
      check_equal("pred_taken_o", taken_bits(fetch_pc_i), pred_taken_o);
    end
  endtask

  // a few rows only, with random upper bits for aliasing
  task automatic queue_random_update(input logic dbg);
    nx_upd_valid = ($urandom_range(0, 3) != 0);
    nx_upd_pc    = make_pc(4 + 5 * $urandom_range(0, 3), $urandom_range(0, 1));
    nx_upd_taken = ($urandom_range(0, 2) != 0);
    nx_debug     = dbg;
  endtask

  task automatic pick_fetch_pc();
    if ($urandom_range(0, 1) == 1) begin
      nx_fetch_pc = make_pc(4 + 5 * $urandom_range(0, 3), 0);
    end else begin
      nx_fetch_pc = make_pc($urandom_range(0, NR_ROWS - 1), 0);
    end
  endtask

  task automatic run_flush(input logic with_upd);
    int n;
    nx_req = 1'b1;
    n = 0;
    do begin
      if (with_upd) begin
        queue_random_update(1'b0);
      end
      next_cycle();
      n++;
    end while (!flush_ack_o && n < 4 * NR_ROWS);
    if (!flush_ack_o) begin
      errors++;
      $display("flush_ack_o did not rise within %0d cycles of the request", 4 * NR_ROWS);
    end
    nx_req = 1'b0;
    nx_upd_valid = 1'b0;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (flush_ack_o && n < 8);
    if (flush_ack_o) begin
      errors++;
      $display("flush_ack_o stayed high after flush_req_i was dropped");
    end
  endtask

  task automatic scan_rows(input logic all_clear);
    for (int r = 0; r < NR_ROWS; r++) begin
      nx_fetch_pc = make_pc(r, 0);
      next_cycle();
      if (all_clear) begin
        check_equal("row valid", '0, pred_valid_o);
        check_equal("row taken", '1, pred_taken_o);
      end
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    vaddr_t sat_pc;
    vaddr_t pc_t;
    vaddr_t pc_n;
    errors = 0;
    checks = 0;
    test_name = "reset";
    void'($urandom(32'h41be27af));
    rst_ni       = 1'b0;
    fetch_pc_i   = '0;
    upd_valid_i  = 1'b0;
    upd_pc_i     = '0;
    upd_taken_i  = 1'b0;
    debug_mode_i = 1'b0;
    flush_req_i  = 1'b0;
    nx_fetch_pc  = '0;
    nx_upd_valid = 1'b0;
    nx_upd_pc    = '0;
    nx_upd_taken = 1'b0;
    nx_debug     = 1'b0;
    nx_req       = 1'b0;
    reset_table_model();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    repeat (20) begin
      nx_fetch_pc = make_pc($urandom_range(0, NR_ROWS - 1), 0);
      next_cycle();
      check_equal("valid after reset", '0, pred_valid_o);
    end

    test_name = "random";
    repeat (400) begin
      queue_random_update(1'b0);
      pick_fetch_pc();
      next_cycle();
    end
    nx_upd_valid = 1'b0;

    // row 25 is outside the random set, so it starts invalid at 00
    test_name = "saturate";
    sat_pc       = make_pc(25, 1);
    nx_fetch_pc  = sat_pc;
    nx_upd_pc    = sat_pc;
    nx_upd_taken = 1'b1;
    nx_upd_valid = 1'b1;
    repeat (4) next_cycle();
    nx_upd_valid = 1'b0;
    repeat (2) next_cycle();
    check_equal("after taken run", 2'b10, pred_taken_o);
    for (int i = 0; i < 2; i++) begin
      nx_upd_taken = 1'b0;
      nx_upd_valid = 1'b1;
      next_cycle();
      nx_upd_valid = 1'b0;
      repeat (2) next_cycle();
      check_equal("after not-taken", (i == 0) ? 2'b10 : 2'b00, pred_taken_o);
    end

    test_name = "debug";
    repeat (100) begin
      queue_random_update(1'b1);
      pick_fetch_pc();
      next_cycle();
    end
    nx_debug = 1'b0;
    nx_upd_valid = 1'b0;

    test_name = "flush";
    run_flush(1'b0);
    scan_rows(1'b1);
    // from 10 one taken step gives 11, one not-taken step gives 01
    pc_t = make_pc(30, 0);
    pc_n = make_pc(30, 1);
    nx_fetch_pc  = pc_t;
    nx_upd_pc    = pc_t;
    nx_upd_taken = 1'b1;
    nx_upd_valid = 1'b1;
    next_cycle();
    nx_upd_pc    = pc_n;
    nx_upd_taken = 1'b0;
    next_cycle();
    nx_upd_valid = 1'b0;
    repeat (2) next_cycle();
    check_equal("valid after update", 2'b11, pred_valid_o);
    check_equal("taken after update", 2'b01, pred_taken_o);

    test_name = "flush_busy";
    repeat (100) begin
      queue_random_update(1'b0);
      pick_fetch_pc();
      next_cycle();
    end
    run_flush(1'b1);
    scan_rows(1'b0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/bht_table.sv ====
// branch history table storage with prediction read, update read, write port and row clear
`timescale 1ns/1ps

module bht_table
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // prediction read
  input  row_idx_t  rd_row_i,
  output slot_vec_t pred_valid_o,
  output slot_vec_t pred_taken_o,
  // update read
  input  row_idx_t  upd_row_i,
  input  slot_idx_t upd_slot_i,
  output logic      upd_valid_o,
  output sat_cnt_t  upd_cnt_o,
  // update write
  input  logic      wr_en_i,
  input  row_idx_t  wr_row_i,
  input  slot_idx_t wr_slot_i,
  input  sat_cnt_t  wr_cnt_i,
  // row clear from the flush sweep
  input  logic      clr_en_i,
  input  row_idx_t  clr_row_i
);

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  logic     valid_q [NR_ROWS-1:0][INSTR_PER_FETCH-1:0];
  sat_cnt_t cnt_q   [NR_ROWS-1:0][INSTR_PER_FETCH-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          valid_q[r][s] <= 1'b0;
          cnt_q[r][s]   <= 2'b00;
        end
      end
    end else if (clr_en_i) begin
      // the whole row goes invalid and weakly taken
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        valid_q[clr_row_i][s] <= 1'b0;
        cnt_q[clr_row_i][s]   <= FLUSH_CNT_INIT;
      end
    end else if (wr_en_i) begin
      valid_q[wr_row_i][wr_slot_i] <= 1'b1;
      cnt_q[wr_row_i][wr_slot_i]   <= wr_cnt_i;
    end
  end

  // ------------------------------------------------------------
  // read ports
  // ------------------------------------------------------------
  // prediction: every slot of the selected row at once
  always_comb begin
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      pred_valid_o[s] = valid_q[rd_row_i][s];
      pred_taken_o[s] = cnt_q[rd_row_i][s][1];
    end
  end

  // single entry for the update stage
  assign upd_valid_o = valid_q[upd_row_i][upd_slot_i];
  assign upd_cnt_o   = cnt_q[upd_row_i][upd_slot_i];

  // update stage and flush sequencer must never collide on the table
  a_no_wr_during_clr: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(wr_en_i && clr_en_i)
  ) else $error("bht_table: write and row clear in the same cycle");

endmodule

// ==== verilog/bht_update.sv ====
// update stage: captures a resolved branch, reads its entry and writes back the stepped counter
`timescale 1ns/1ps

module bht_update
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // resolved branch from execute
  input  logic      upd_valid_i,
  input  vaddr_t    upd_pc_i,
  input  logic      upd_taken_i,
  input  logic      debug_mode_i,
  // flush in progress
  input  logic      sweep_busy_i,
  // entry read back from the table
  output row_idx_t  rd_row_o,
  output slot_idx_t rd_slot_o,
  input  logic      ent_valid_i,
  input  sat_cnt_t  ent_cnt_i,
  // write port of the table
  output logic      wr_en_o,
  output row_idx_t  wr_row_o,
  output slot_idx_t wr_slot_o,
  output sat_cnt_t  wr_cnt_o
);

  logic      accept;
  logic      pend_q;
  row_idx_t  row_q;
  slot_idx_t slot_q;
  logic      taken_q;
  sat_cnt_t  cnt_nxt;

  // no new work while debugging or while the table is being swept
  assign accept = upd_valid_i && !debug_mode_i && !sweep_busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      row_q   <= upd_pc_i[ROW_LSB +: ROW_W];
      slot_q  <= upd_pc_i[OFFSET +: SLOT_W];
      taken_q <= upd_taken_i;
    end
  end

  assign rd_row_o  = row_q;
  assign rd_slot_o = slot_q;

  // ------------------------------------------------------------
  // saturating step toward the outcome
  // ------------------------------------------------------------
  always_comb begin
    cnt_nxt = ent_cnt_i;
    if (taken_q) begin
      if (ent_cnt_i != 2'b11) begin
        cnt_nxt = ent_cnt_i + 2'd1;
      end
    end else begin
      if (ent_cnt_i != 2'b00) begin
        cnt_nxt = ent_cnt_i - 2'd1;
      end
    end
  end

  // a valid entry that would not change needs no write
  assign wr_en_o   = pend_q && !sweep_busy_i && (!ent_valid_i || (cnt_nxt != ent_cnt_i));
  assign wr_row_o  = row_q;
  assign wr_slot_o = slot_q;
  assign wr_cnt_o  = cnt_nxt;

  // nothing reaches the table while busy, nor from an update that arrived while busy
  a_no_wr_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (sweep_busy_i || $past(sweep_busy_i)) |-> !wr_en_o
  ) else $error("bht_update: table write while a flush is running");

endmodule

// ==== verilog/bp_cfg_pkg.sv ====
// sizing constants for the branch prediction unit: address, fetch group, table and index bits
package bp_cfg_pkg;

  // ------------------------------------------------------------
  // address and fetch group
  // ------------------------------------------------------------
  localparam int unsigned VLEN            = 32;
  // 2-byte alignment gives two slots in a 4-byte fetch group
  localparam int unsigned INSTR_PER_FETCH = 2;

  // ------------------------------------------------------------
  // table geometry
  // ------------------------------------------------------------
  localparam int unsigned NR_ENTRIES = 64;
  localparam int unsigned NR_ROWS    = NR_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_W      = $clog2(NR_ROWS);
  localparam int unsigned SLOT_W     = $clog2(INSTR_PER_FETCH);

  // ------------------------------------------------------------
  // index positions inside an address
  // ------------------------------------------------------------
  // bit 0 is always zero, so indexing starts one bit up
  localparam int unsigned OFFSET  = 1;
  // row bits sit directly above the slot bit
  localparam int unsigned ROW_LSB = OFFSET + SLOT_W;

  // weakly taken, written into every entry by a flush
  localparam logic [1:0] FLUSH_CNT_INIT = 2'b10;

endpackage

// ==== verilog/bp_types_pkg.sv ====
// vector typedefs for addresses, table indices and counters, and the flush state enum
package bp_types_pkg;

  import bp_cfg_pkg::*;

  // ------------------------------------------------------------
  // address and index vectors
  // ------------------------------------------------------------
  // virtual address as seen by fetch and by branch resolution
  typedef logic [VLEN-1:0] vaddr_t;

  // row of the history table
  typedef logic [ROW_W-1:0] row_idx_t;

  // slot inside a row, one per instruction of the fetch group
  typedef logic [SLOT_W-1:0] slot_idx_t;

  // ------------------------------------------------------------
  // entry contents
  // ------------------------------------------------------------
  // 2-bit saturating counter, upper bit is the taken prediction
  typedef logic [1:0] sat_cnt_t;

  // one bit per fetch slot
  typedef logic [INSTR_PER_FETCH-1:0] slot_vec_t;

  // ------------------------------------------------------------
  // flush sequencing
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    FLUSH_IDLE  = 2'b00,
    FLUSH_SWEEP = 2'b01,
    FLUSH_ACK   = 2'b10
  } flush_state_e;

endpackage

// ==== verilog/bp_unit.sv ====
// branch prediction unit top: history table, update stage, sweep counter and flush FSM
`timescale 1ns/1ps

module bp_unit
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // prediction from the fetch address
  input  vaddr_t    fetch_pc_i,
  output slot_vec_t pred_valid_o,
  output slot_vec_t pred_taken_o,
  // resolved branches
  input  logic      upd_valid_i,
  input  vaddr_t    upd_pc_i,
  input  logic      upd_taken_i,
  input  logic      debug_mode_i,
  // flush handshake
  input  logic      flush_req_i,
  output logic      flush_ack_o
);

  // ------------------------------------------------------------
  // internal wiring
  // ------------------------------------------------------------
  row_idx_t  pred_row;
  row_idx_t  upd_rd_row;
  slot_idx_t upd_rd_slot;
  logic      ent_valid;
  sat_cnt_t  ent_cnt;
  logic      wr_en;
  row_idx_t  wr_row;
  slot_idx_t wr_slot;
  sat_cnt_t  wr_cnt;
  logic      sweep_en;
  logic      sweep_clr;
  logic      sweep_last;
  logic      sweep_busy;
  logic      clear;
  row_idx_t  clear_row;

  // all slots of a row are predicted together, so only the row is needed
  assign pred_row = fetch_pc_i[ROW_LSB +: ROW_W];

  bht_table u_bht_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_row_i     (pred_row),
    .pred_valid_o (pred_valid_o),
    .pred_taken_o (pred_taken_o),
    .upd_row_i    (upd_rd_row),
    .upd_slot_i   (upd_rd_slot),
    .upd_valid_o  (ent_valid),
    .upd_cnt_o    (ent_cnt),
    .wr_en_i      (wr_en),
    .wr_row_i     (wr_row),
    .wr_slot_i    (wr_slot),
    .wr_cnt_i     (wr_cnt),
    .clr_en_i     (clear),
    .clr_row_i    (clear_row)
  );

  bht_update u_bht_update (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .upd_valid_i  (upd_valid_i),
    .upd_pc_i     (upd_pc_i),
    .upd_taken_i  (upd_taken_i),
    .debug_mode_i (debug_mode_i),
    .sweep_busy_i (sweep_busy),
    .rd_row_o     (upd_rd_row),
    .rd_slot_o    (upd_rd_slot),
    .ent_valid_i  (ent_valid),
    .ent_cnt_i    (ent_cnt),
    .wr_en_o      (wr_en),
    .wr_row_o     (wr_row),
    .wr_slot_o    (wr_slot),
    .wr_cnt_o     (wr_cnt)
  );

  sweep_counter u_sweep_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (sweep_clr),
    .en_i   (sweep_en),
    .row_o  (clear_row),
    .last_o (sweep_last)
  );

  flush_fsm u_flush_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_req_i  (flush_req_i),
    .flush_ack_o  (flush_ack_o),
    .sweep_en_o   (sweep_en),
    .sweep_clr_o  (sweep_clr),
    .sweep_last_i (sweep_last),
    .clear_o      (clear),
    .sweep_busy_o (sweep_busy)
  );

endmodule

// ==== verilog/flush_fsm.sv ====
// flush FSM: four-phase req/ack handshake and sequencing of the row sweep
`timescale 1ns/1ps

module flush_fsm
  import bp_types_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  // four-phase handshake with the requester
  input  logic flush_req_i,
  output logic flush_ack_o,
  // sweep counter control
  output logic sweep_en_o,
  output logic sweep_clr_o,
  input  logic sweep_last_i,
  // table clear strobe and update blocking
  output logic clear_o,
  output logic sweep_busy_o
);

  flush_state_e state_q;
  flush_state_e state_d;
  logic         start;

  // request seen while idle kicks off a sweep at this edge
  assign start = (state_q == FLUSH_IDLE) && flush_req_i;

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      FLUSH_IDLE: begin
        if (flush_req_i) begin
          state_d = FLUSH_SWEEP;
        end
      end
      FLUSH_SWEEP: begin
        // leave once the last row has been cleared
        if (sweep_last_i) begin
          state_d = FLUSH_ACK;
        end
      end
      FLUSH_ACK: begin
        // hold ack until the requester lets go
        if (!flush_req_i) begin
          state_d = FLUSH_IDLE;
        end
      end
      default: begin
        state_d = FLUSH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign sweep_clr_o  = start;
  assign sweep_en_o   = (state_q == FLUSH_SWEEP);
  assign clear_o      = (state_q == FLUSH_SWEEP);
  assign flush_ack_o  = (state_q == FLUSH_ACK);
  // also covers the accepting edge so no update slips in before the sweep
  assign sweep_busy_o = start || (state_q == FLUSH_SWEEP);

  // requester has to keep req high until the ack arrives
  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(flush_ack_o) |-> flush_req_i
  ) else $error("flush_fsm: ack raised without a pending request");

endmodule

// ==== verilog/sweep_counter.sv ====
// row counter that walks the table during a flush and flags the last row
`timescale 1ns/1ps

module sweep_counter
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // restart at row zero
  input  logic     clr_i,
  // step to the next row
  input  logic     en_i,
  output row_idx_t row_o,
  output logic     last_o
);

  row_idx_t row_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q <= '0;
    end else if (clr_i) begin
      row_q <= '0;
    end else if (en_i) begin
      // wraps back to zero after the last row
      row_q <= row_q + row_idx_t'(1);
    end
  end

  assign row_o  = row_q;
  assign last_o = (row_q == row_idx_t'(NR_ROWS - 1));

endmodule
